// ==== files.f ====
source/sata_prims_pkg.sv
source/sata_phy_pkg.sv
source/oob_burst_gen.sv
source/oob_burst_det.sv
source/tx_word_mux.sv
source/phy_link_ctrl.sv
source/sata_phy_link.sv
tests/sata_phy_link_chk.sv
tests/sata_phy_link_tb.sv

// ==== tests/sata_phy_link_tb.sv ====
//--------------------
// testbench for the SATA host PHY link controller, default top-level timing
// the device model answers OOB, dial and SYNC on the DUT clock
//--------------------
`default_nettype none

module sata_phy_link_tb;
    import sata_prims_pkg::*;
    import sata_phy_pkg::*;

    localparam int wait_limit_c = 1000;   // cycles for any single wait

    logic        i_tx_reset;   // clock
    logic        i_tx_clk;     // reset, active high
    logic        i_rx_locked;
    logic        i_rx_sigdet;
    rx_dword_t   i_rx;
    tx_dword_t   i_tx;
    tx_dword_t   o_tx;
    logic        o_tx_elecidle;
    logic        o_tx_ready;
    logic        o_linkup;
    sata_gen_e   o_sata_gen;
    logic [31:0] rng_state = 32'd5389;
    int          error_cnt = 0;

    sata_phy_link i_sata_phy_link (
        .i_tx_reset    (i_tx_reset),
        .i_tx_clk      (i_tx_clk),
        .i_rx_locked   (i_rx_locked),
        .i_rx_sigdet   (i_rx_sigdet),
        .i_rx          (i_rx),
        .i_tx          (i_tx),
        .o_tx          (o_tx),
        .o_tx_elecidle (o_tx_elecidle),
        .o_tx_ready    (o_tx_ready),
        .o_linkup      (o_linkup),
        .o_sata_gen    (o_sata_gen)
    );

    initial begin
        i_tx_reset = 1'b0;
        forever #50 i_tx_reset = ~i_tx_reset;   // period 100
    end

    //--------------------
    // helpers
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic tx_dword_t make_tx(input logic [31:0] data, input dword_kind_e kind);
        tx_dword_t w;
        w.data = data;
        w.kind = kind;
        return w;
    endfunction

    function automatic rx_dword_t make_rx(input logic [31:0] data, input logic [3:0] sync);
        rx_dword_t w;
        w.data = data;
        w.kind = kind_prim;   // device answers only with primitives
        w.sync = sync;
        return w;
    endfunction

    task automatic stop_on_error(input string msg);
        error_cnt++;
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    //--------------------
    // compare tasks
    task automatic check_tx_dword(input string name, input tx_dword_t got, input tx_dword_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERROR %s: got 0x%09h expected 0x%09h", name, got, exp));
    endtask

    task automatic check_gen(input string name, input sata_gen_e got, input sata_gen_e exp);
        if (got !== exp)
            stop_on_error($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            stop_on_error($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    //--------------------
    // waits, entered on a falling edge
    task automatic wait_elecidle(input logic level);
        int n;
        n = 0;
        while (o_tx_elecidle !== level) begin
            @(negedge i_tx_reset);
            n++;
            if (n > wait_limit_c)
                stop_on_error($sformatf("timeout waiting for o_tx_elecidle = %0b", level));
        end
    endtask

    task automatic wait_tx_data(input logic [31:0] data);
        int n;
        n = 0;
        while (o_tx.data !== data) begin
            @(negedge i_tx_reset);
            n++;
            if (n > wait_limit_c)
                stop_on_error($sformatf("timeout waiting for o_tx data 0x%08h", data));
        end
    endtask

    task automatic wait_linkup(input logic level);
        int n;
        n = 0;
        while (o_linkup !== level) begin
            @(negedge i_tx_reset);
            n++;
            if (n > wait_limit_c)
                stop_on_error($sformatf("timeout waiting for o_linkup = %0b", level));
        end
    endtask

    task automatic apply_reset();
        @(posedge i_tx_reset);
        i_tx_clk    <= 1'b1;
        i_rx_locked <= 1'b0;
        i_rx_sigdet <= 1'b0;
        i_rx        <= '0;
        i_tx        <= '0;
        repeat (2) @(posedge i_tx_reset);
        i_tx_clk <= 1'b0;
        @(negedge i_tx_reset);
    endtask

    task automatic check_reset_values();
        check_bit("o_linkup", o_linkup, 1'b0);
        check_gen("o_sata_gen", o_sata_gen, gen_none);
        check_bit("o_tx_elecidle", o_tx_elecidle, 1'b1);
        check_tx_dword("o_tx", o_tx, make_tx(32'h0, kind_data));
        check_bit("o_tx_ready", o_tx_ready, 1'b1);
    endtask

    //--------------------
    // device model
    task automatic drive_sigdet(input logic level, input int cycles);
        repeat (cycles) begin
            @(posedge i_tx_reset);
            i_rx_sigdet <= level;
        end
    endtask

    // opening burst plus det_bursts_c burst/gap pairs, ends idle
    task automatic send_oob(input int gap);
        for (int b = 0; b <= det_bursts_c; b++) begin
            drive_sigdet(1'b1, burst_len_c);
            drive_sigdet(1'b0, gap);
        end
    endtask

    // host train, elecidle low marks a burst
    task automatic measure_train(input int gap);
        wait_elecidle(1'b1);   // dial keeps the line active
        wait_elecidle(1'b0);
        for (int b = 0; b < num_bursts_c; b++) begin
            for (int k = 0; k < burst_len_c; k++) begin
                if (b != 0 || k != 0)
                    @(negedge i_tx_reset);
                check_bit("o_tx_elecidle", o_tx_elecidle, 1'b0);
            end
            for (int k = 0; k < gap; k++) begin
                @(negedge i_tx_reset);
                check_bit("o_tx_elecidle", o_tx_elecidle, 1'b1);
            end
        end
        @(negedge i_tx_reset);
        check_bit("o_tx_elecidle", o_tx_elecidle, 1'b1);   // no extra burst
    endtask

    // dial is left unanswered on the first tries
    task automatic link_up(input int fails, input sata_gen_e exp_gen);
        for (int t = 0; t <= fails; t++) begin
            measure_train(cominit_gap_c);   // COMRESET
            fork
                send_oob(cominit_gap_c);
                measure_train(comwake_gap_c);
            join
            send_oob(comwake_gap_c);
            drive_sigdet(1'b1, 1);          // held high, end of OOB
            @(negedge i_tx_reset);
            wait_tx_data(dial_data_c);
            check_tx_dword("o_tx", o_tx, make_tx(dial_data_c, kind_data));
        end
        @(posedge i_tx_reset);
        i_rx <= make_rx(prim_align_c, 4'hF);
        @(negedge i_tx_reset);
        wait_tx_data(prim_align_c);
        check_tx_dword("o_tx", o_tx, make_tx(prim_align_c, kind_prim));
        @(posedge i_tx_reset);
        i_rx <= make_rx(prim_sync_c, 4'hF);
        @(negedge i_tx_reset);
        wait_linkup(1'b1);
        check_gen("o_sata_gen", o_sata_gen, exp_gen);
        check_bit("o_tx_elecidle", o_tx_elecidle, 1'b0);
    endtask

    // random user words against a one-register model
    task automatic run_data(input int cycles);
        tx_dword_t   word;
        tx_dword_t   prev_word;
        logic        prev_ready;
        logic        armed;
        logic [31:0] rnd;
        int          low_run;
        int          last_start;
        int          pairs;
        prev_word  = '0;
        prev_ready = 1'b0;
        armed      = 1'b0;
        low_run    = 0;
        last_start = 0;
        pairs      = 0;
        for (int c = 0; c < cycles; c++) begin
            @(posedge i_tx_reset);
            rnd  = lcg_next();
            word = make_tx(lcg_next(), dword_kind_e'(rnd[31]));
            i_tx <= word;
            @(negedge i_tx_reset);
            if (c != 0)
                check_tx_dword("o_tx", o_tx,
                               prev_ready ? prev_word : make_tx(prim_align_c, kind_prim));
            if (!o_tx_ready && armed) begin
                if (low_run == 0) begin   // start of an ALIGN pair
                    if (pairs != 0)
                        check_count("ALIGN pair spacing", c - last_start, align_period_c);
                    last_start = c;
                    pairs++;
                end
                low_run++;
            end else if (o_tx_ready) begin
                if (low_run != 0)
                    check_count("o_tx_ready low run", low_run, 2);
                low_run = 0;
                armed   = 1'b1;       // skip a pair cut at the start
            end
            prev_word  = word;
            prev_ready = o_tx_ready;
        end
        if (pairs < 2)
            stop_on_error("fewer than two ALIGN pairs were seen during the data run");
    endtask

    //--------------------
    // sequence
    initial begin
        i_tx_clk    = 1'b1;
        i_rx_locked = 1'b0;
        i_rx_sigdet = 1'b0;
        i_rx        = '0;
        i_tx        = '0;
        apply_reset();
        check_reset_values();
        repeat (100) begin                 // no lock, no OOB
            @(negedge i_tx_reset);
            check_bit("o_tx_elecidle", o_tx_elecidle, 1'b1);
        end
        @(posedge i_tx_reset);
        i_rx_locked <= 1'b1;
        @(negedge i_tx_reset);
        link_up(0, gen3);
        run_data(3 * align_period_c);
        @(posedge i_tx_reset);
        i_rx <= make_rx(prim_sync_c, 4'hE);   // byte 0 out of sync
        @(negedge i_tx_reset);
        wait_linkup(1'b0);
        check_gen("o_sata_gen", o_sata_gen, gen_none);
        link_up(3, gen3);                  // 3 -> 2 -> 1 -> 3
        apply_reset();
        check_reset_values();
        @(posedge i_tx_reset);
        i_rx_locked <= 1'b1;
        @(negedge i_tx_reset);
        link_up(1, gen2);
        if (error_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/sata_phy_link_chk.sv ====
//--------------------
// output checks bound into the PHY link top level
// sampled on the DUT clock, idle during reset
//--------------------
`default_nettype none

module sata_phy_link_chk (
    input logic                      i_tx_reset,   // clock
    input logic                      i_tx_clk,     // reset, active high
    input sata_prims_pkg::tx_dword_t i_tx_word,
    input logic                      i_ready,
    input logic                      i_elecidle,
    input logic                      i_linkup,
    input sata_prims_pkg::sata_gen_e i_gen
);
    import sata_prims_pkg::*;

    // ALIGN slot follows every low ready
    a_ready_align: assert property (@(posedge i_tx_reset) disable iff (i_tx_clk)
        !i_ready |=> (i_tx_word.data == prim_align_c) && (i_tx_word.kind == kind_prim))
        else $error("o_tx is not ALIGN after a low o_tx_ready");

    a_linkup_gen: assert property (@(posedge i_tx_reset) disable iff (i_tx_clk)
        i_linkup |-> (i_gen != gen_none))
        else $error("o_sata_gen reads none while o_linkup is high");

    // line active while the link is up
    a_linkup_active: assert property (@(posedge i_tx_reset) disable iff (i_tx_clk)
        i_linkup |-> !i_elecidle)
        else $error("o_tx_elecidle is high while o_linkup is high");

endmodule

bind sata_phy_link sata_phy_link_chk i_sata_phy_link_chk (
    .i_tx_reset   (i_tx_reset),
    .i_tx_clk     (i_tx_clk),
    .i_tx_word    (o_tx),
    .i_ready      (o_tx_ready),
    .i_elecidle   (o_tx_elecidle),
    .i_linkup     (o_linkup),
    .i_gen        (o_sata_gen)
);

`default_nettype wire

// ==== source/sata_phy_link.sv ====
//--------------------
// SATA host PHY link controller, single clock
// received dwords must arrive byte aligned on this clock
//--------------------
`default_nettype none

module sata_phy_link #(
    parameter int unsigned BURST_LEN    = sata_phy_pkg::burst_len_c,
    parameter int unsigned COMINIT_GAP  = sata_phy_pkg::cominit_gap_c,
    parameter int unsigned COMWAKE_GAP  = sata_phy_pkg::comwake_gap_c,
    parameter int unsigned NUM_BURSTS   = sata_phy_pkg::num_bursts_c,
    parameter int unsigned DET_BURSTS   = sata_phy_pkg::det_bursts_c,
    parameter int unsigned GAP_TOL      = sata_phy_pkg::gap_tol_c,
    parameter int unsigned FINISH_LEN   = sata_phy_pkg::finish_len_c,
    parameter int unsigned TIMEOUT      = sata_phy_pkg::timeout_c,
    parameter int unsigned SETTLE       = sata_phy_pkg::settle_c,
    parameter int unsigned LINKUP_DELAY = sata_phy_pkg::linkup_delay_c,
    parameter int unsigned ALIGN_PERIOD = sata_phy_pkg::align_period_c
) (
    input  logic                      i_tx_reset,   // clock
    input  logic                      i_tx_clk,     // async reset, active high
    input  logic                      i_rx_locked,
    input  logic                      i_rx_sigdet,
    input  sata_prims_pkg::rx_dword_t i_rx,
    input  sata_prims_pkg::tx_dword_t i_tx,
    output sata_prims_pkg::tx_dword_t o_tx,
    output logic                      o_tx_elecidle,
    output logic                      o_tx_ready,
    output logic                      o_linkup,
    output sata_prims_pkg::sata_gen_e o_sata_gen
);
    import sata_phy_pkg::*;

    oob_cmd_t   oob_cmd;
    oob_event_t oob_evt;
    logic       oob_ready;
    logic       oob_done;
    logic       dial_sel;
    logic       link_ready;

    //--------------------
    phy_link_ctrl #(
        .TIMEOUT      (TIMEOUT),
        .SETTLE       (SETTLE),
        .LINKUP_DELAY (LINKUP_DELAY)
    ) i_phy_link_ctrl (
        .i_tx_reset   (i_tx_reset),
        .i_tx_clk     (i_tx_clk),
        .i_rx_locked  (i_rx_locked),
        .i_rx_sigdet  (i_rx_sigdet),
        .i_rx         (i_rx),
        .i_oob_evt    (oob_evt),
        .i_oob_ready  (oob_ready),
        .o_oob_cmd    (oob_cmd),
        .o_oob_done   (oob_done),
        .o_dial_sel   (dial_sel),
        .o_link_ready (link_ready),
        .o_linkup     (o_linkup),
        .o_sata_gen   (o_sata_gen)
    );

    oob_burst_gen #(
        .BURST_LEN   (BURST_LEN),
        .COMINIT_GAP (COMINIT_GAP),
        .COMWAKE_GAP (COMWAKE_GAP),
        .NUM_BURSTS  (NUM_BURSTS)
    ) i_oob_burst_gen (
        .i_tx_reset  (i_tx_reset),
        .i_tx_clk    (i_tx_clk),
        .i_cmd       (oob_cmd),
        .i_oob_done  (oob_done),
        .o_ready     (oob_ready),
        .o_elecidle  (o_tx_elecidle)
    );

    oob_burst_det #(
        .BURST_LEN   (BURST_LEN),
        .COMINIT_GAP (COMINIT_GAP),
        .COMWAKE_GAP (COMWAKE_GAP),
        .DET_BURSTS  (DET_BURSTS),
        .GAP_TOL     (GAP_TOL),
        .FINISH_LEN  (FINISH_LEN)
    ) i_oob_burst_det (
        .i_tx_reset  (i_tx_reset),
        .i_tx_clk    (i_tx_clk),
        .i_sigdet    (i_rx_sigdet),
        .o_evt       (oob_evt)
    );

    tx_word_mux #(
        .ALIGN_PERIOD (ALIGN_PERIOD)
    ) i_tx_word_mux (
        .i_tx_reset   (i_tx_reset),
        .i_tx_clk     (i_tx_clk),
        .i_dial_sel   (dial_sel),
        .i_link_ready (link_ready),
        .i_tx         (i_tx),
        .o_tx         (o_tx),
        .o_tx_ready   (o_tx_ready)
    );

endmodule

`default_nettype wire

// ==== source/phy_link_ctrl.sv ====
//--------------------
// link-up FSM with timeout, generation fallback and link-up delay
// SETTLE must not exceed TIMEOUT by more than the counter width allows
// generation steps 3 -> 2 -> 1 -> 3 on every dial timeout
//--------------------
`default_nettype none

module phy_link_ctrl #(
    parameter int unsigned TIMEOUT      = 400,
    parameter int unsigned SETTLE       = 20,
    parameter int unsigned LINKUP_DELAY = 31
) (
    input  logic                     i_tx_reset,   // clock
    input  logic                     i_tx_clk,     // async reset, active high
    input  logic                     i_rx_locked,
    input  logic                     i_rx_sigdet,
    input  sata_prims_pkg::rx_dword_t i_rx,
    input  sata_phy_pkg::oob_event_t i_oob_evt,
    input  logic                     i_oob_ready,
    output sata_phy_pkg::oob_cmd_t   o_oob_cmd,
    output logic                     o_oob_done,   // host drives dial or data
    output logic                     o_dial_sel,
    output logic                     o_link_ready,
    output logic                     o_linkup,
    output sata_prims_pkg::sata_gen_e o_sata_gen
);
    import sata_prims_pkg::*;
    import sata_phy_pkg::*;

    localparam int unsigned CNT_MAX = (TIMEOUT > SETTLE) ? TIMEOUT : SETTLE;
    localparam int unsigned CNT_W   = $clog2(CNT_MAX + 1);
    localparam int unsigned DLY_W   = $clog2(LINKUP_DELAY + 1);

    link_state_e      state_q;
    link_state_e      state_nxt;
    logic [CNT_W-1:0] tmo_cnt;
    logic [DLY_W-1:0] dly_cnt;
    sata_gen_e        gen_q;
    logic             counting;
    logic             timeout_hit;
    logic             settle_hit;
    logic             align_seen;
    logic             sync_seen;

    //--------------------
    // receive word decode
    assign align_seen = (i_rx.data == prim_align_c) && (i_rx.kind == kind_prim) && (&i_rx.sync);
    assign sync_seen  = (i_rx.data == prim_sync_c) && (i_rx.kind == kind_prim);

    assign counting    = state_q inside {st_wait_cominit, st_wait_comwake, st_wait_oobfinish,
                                         st_send_dial, st_wait_settle, st_send_align};
    assign timeout_hit = (tmo_cnt == CNT_W'(TIMEOUT - 1));
    assign settle_hit  = (tmo_cnt == CNT_W'(SETTLE - 1));

    //--------------------
    // next state
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            st_idle:             if (i_rx_locked) state_nxt = st_send_comreset;
            st_send_comreset:    state_nxt = st_suspend_comreset;   // one-cycle command
            st_suspend_comreset: if (i_oob_ready) state_nxt = st_wait_cominit;
            st_wait_cominit: begin
                if (i_oob_evt.cominit)
                    state_nxt = st_send_comwake;
                else if (timeout_hit)
                    state_nxt = st_idle;
            end
            st_send_comwake:     state_nxt = st_suspend_comwake;
            st_suspend_comwake:  if (i_oob_ready) state_nxt = st_wait_comwake;
            st_wait_comwake: begin
                if (i_oob_evt.comwake)
                    state_nxt = st_wait_oobfinish;
                else if (timeout_hit)
                    state_nxt = st_idle;
            end
            st_wait_oobfinish: begin
                if (i_oob_evt.oobfinish)
                    state_nxt = st_send_dial;
                else if (timeout_hit)
                    state_nxt = st_idle;
            end
            st_send_dial: begin
                if (align_seen)
                    state_nxt = st_send_align;
                else if (timeout_hit)
                    state_nxt = st_step_gen;    // try next generation
            end
            st_step_gen:         state_nxt = st_wait_settle;
            st_wait_settle:      if (settle_hit) state_nxt = st_idle;
            st_send_align: begin
                if (sync_seen)
                    state_nxt = st_link_ready;
                else if (timeout_hit)
                    state_nxt = st_idle;
            end
            st_link_ready:       if (!(i_rx_sigdet && (&i_rx.sync))) state_nxt = st_idle;
            default:             state_nxt = st_idle;
        endcase
    end

    //--------------------
    // state, timeout counter, generation
    always_ff @(posedge i_tx_reset or posedge i_tx_clk) begin
        if (i_tx_clk) begin
            state_q <= st_idle;
            tmo_cnt <= '0;
            gen_q   <= gen3;
        end else begin
            state_q <= state_nxt;
            // clears on any state change
            tmo_cnt <= (counting && (state_nxt == state_q)) ? tmo_cnt + 1'b1 : '0;
            if ((state_q == st_send_dial) && (state_nxt == st_step_gen)) begin
                case (gen_q)
                    gen1:    gen_q <= gen3;   // wrap around
                    gen2:    gen_q <= gen1;
                    default: gen_q <= gen2;
                endcase
            end
        end
    end

    // link-up delay, saturating
    always_ff @(posedge i_tx_reset or posedge i_tx_clk) begin
        if (i_tx_clk) begin
            dly_cnt  <= '0;
            o_linkup <= 1'b0;
        end else begin
            if (o_link_ready)
                dly_cnt <= dly_cnt + DLY_W'(dly_cnt != DLY_W'(LINKUP_DELAY));
            else
                dly_cnt <= '0;
            o_linkup <= o_link_ready && (dly_cnt == DLY_W'(LINKUP_DELAY));
        end
    end

    //--------------------
    // state decode
    assign o_oob_cmd    = '{cominit: (state_q == st_send_comreset),
                            comwake: (state_q == st_send_comwake)};
    assign o_dial_sel   = (state_q == st_send_dial);
    assign o_link_ready = (state_q == st_link_ready);
    assign o_oob_done   = (state_q inside {st_send_dial, st_send_align, st_link_ready}) ||
                          o_linkup;   // line stays active until o_linkup drops
    assign o_sata_gen   = o_linkup ? gen_q : gen_none;   // none until link is up

endmodule

`default_nettype wire

// ==== source/tx_word_mux.sv ====
//--------------------
// registered transmit dword select with periodic ALIGN pairs
// user words offered while o_tx_ready is low are dropped
//--------------------
`default_nettype none

module tx_word_mux #(
    parameter int unsigned ALIGN_PERIOD = 256
) (
    input  logic                      i_tx_reset,   // clock
    input  logic                      i_tx_clk,     // async reset, active high
    input  logic                      i_dial_sel,
    input  logic                      i_link_ready,
    input  sata_prims_pkg::tx_dword_t i_tx,
    output sata_prims_pkg::tx_dword_t o_tx,
    output logic                      o_tx_ready
);
    import sata_prims_pkg::*;

    localparam int unsigned AC_W = $clog2(ALIGN_PERIOD);

    logic [AC_W-1:0] align_cnt;
    logic            align_slot;

    assign align_slot = i_link_ready & (align_cnt < AC_W'(2));   // counts 0 and 1
    assign o_tx_ready = ~align_slot;

    //--------------------
    // ALIGN period counter
    always_ff @(posedge i_tx_reset or posedge i_tx_clk) begin
        if (i_tx_clk)
            align_cnt <= '0;
        else if (!i_link_ready)
            align_cnt <= '0;
        else if (align_cnt == AC_W'(ALIGN_PERIOD - 1))
            align_cnt <= '0;
        else
            align_cnt <= align_cnt + 1'b1;
    end

    // output word register
    always_ff @(posedge i_tx_reset or posedge i_tx_clk) begin
        if (i_tx_clk)
            o_tx <= '0;
        else if (i_dial_sel)
            o_tx <= '{data: dial_data_c, kind: kind_data};
        else if (i_link_ready && !align_slot)
            o_tx <= i_tx;
        else
            o_tx <= '{data: prim_align_c, kind: kind_prim};   // idle filler
    end

endmodule

`default_nettype wire

// ==== source/oob_burst_det.sv ====
//--------------------
// OOB detector on the signal-detect level
// assumes COMINIT_GAP > COMWAKE_GAP + 2*GAP_TOL and BURST_LEN + GAP_TOL < FINISH_LEN
//--------------------
`default_nettype none

module oob_burst_det #(
    parameter int unsigned BURST_LEN   = 4,
    parameter int unsigned COMINIT_GAP = 12,
    parameter int unsigned COMWAKE_GAP = 4,
    parameter int unsigned DET_BURSTS  = 4,
    parameter int unsigned GAP_TOL     = 1,
    parameter int unsigned FINISH_LEN  = 16
) (
    input  logic                     i_tx_reset,   // clock
    input  logic                     i_tx_clk,     // async reset, active high
    input  logic                     i_sigdet,
    output sata_phy_pkg::oob_event_t o_evt
);
    localparam int unsigned LO_MAX = COMINIT_GAP + GAP_TOL + 1;   // beyond any match
    localparam int unsigned LO_W   = $clog2(LO_MAX + 1);
    localparam int unsigned HI_W   = $clog2(FINISH_LEN + 1);
    localparam int unsigned MC_W   = $clog2(DET_BURSTS + 1);

    logic            sigdet_q;
    logic [LO_W-1:0] lo_cnt;     // idle cycles of current gap
    logic [HI_W-1:0] hi_cnt;     // high cycles of current burst
    logic [MC_W-1:0] init_cnt;
    logic [MC_W-1:0] wake_cnt;
    logic            rise;
    logic            fall;
    logic            init_match;
    logic            wake_match;
    logic            long_burst;

    assign rise = i_sigdet & ~sigdet_q;     // ends a gap
    assign fall = ~i_sigdet & sigdet_q;

    //--------------------
    // gap classification
    assign init_match = (lo_cnt >= LO_W'(COMINIT_GAP - GAP_TOL)) &&
                        (lo_cnt <= LO_W'(COMINIT_GAP + GAP_TOL));
    assign wake_match = (lo_cnt >= LO_W'(COMWAKE_GAP - GAP_TOL)) &&
                        (lo_cnt <= LO_W'(COMWAKE_GAP + GAP_TOL));
    assign long_burst = hi_cnt > HI_W'(BURST_LEN + GAP_TOL);   // not an OOB burst

    always_ff @(posedge i_tx_reset or posedge i_tx_clk) begin
        if (i_tx_clk) begin
            sigdet_q <= 1'b0;
            lo_cnt   <= '0;
            hi_cnt   <= '0;
            init_cnt <= '0;
            wake_cnt <= '0;
            o_evt    <= '0;
        end else begin
            sigdet_q <= i_sigdet;
            // saturating run-length counters
            if (i_sigdet)
                lo_cnt <= '0;
            else if (lo_cnt != LO_W'(LO_MAX))
                lo_cnt <= lo_cnt + 1'b1;
            if (!i_sigdet)
                hi_cnt <= '0;                      // rearms oobfinish
            else if (hi_cnt != HI_W'(FINISH_LEN))
                hi_cnt <= hi_cnt + 1'b1;

            o_evt <= '0;                           // pulses only
            o_evt.oobfinish <= i_sigdet && (hi_cnt == HI_W'(FINISH_LEN - 1));

            if (fall && long_burst) begin
                init_cnt <= '0;
                wake_cnt <= '0;
            end else if (rise) begin
                if (init_match) begin
                    wake_cnt <= '0;
                    if (init_cnt == MC_W'(DET_BURSTS - 1)) begin
                        init_cnt      <= '0;
                        o_evt.cominit <= 1'b1;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end else if (wake_match) begin
                    init_cnt <= '0;
                    if (wake_cnt == MC_W'(DET_BURSTS - 1)) begin
                        wake_cnt      <= '0;
                        o_evt.comwake <= 1'b1;
                    end else begin
                        wake_cnt <= wake_cnt + 1'b1;
                    end
                end else begin
                    init_cnt <= '0;                // gap matches neither
                    wake_cnt <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/oob_burst_gen.sv ====
//--------------------
// OOB burst train generator, electrical idle low marks a burst
// commands arriving while a train runs are ignored
//--------------------
`default_nettype none

module oob_burst_gen #(
    parameter int unsigned BURST_LEN   = 4,
    parameter int unsigned COMINIT_GAP = 12,
    parameter int unsigned COMWAKE_GAP = 4,
    parameter int unsigned NUM_BURSTS  = 6
) (
    input  logic                   i_tx_reset,   // clock
    input  logic                   i_tx_clk,     // async reset, active high
    input  sata_phy_pkg::oob_cmd_t i_cmd,
    input  logic                   i_oob_done,
    output logic                   o_ready,
    output logic                   o_elecidle
);
    localparam int unsigned GAP_MAX = (COMINIT_GAP > COMWAKE_GAP) ? COMINIT_GAP : COMWAKE_GAP;
    localparam int unsigned LEN_MAX = (GAP_MAX > BURST_LEN) ? GAP_MAX : BURST_LEN;
    localparam int unsigned PH_W    = $clog2(LEN_MAX + 1);
    localparam int unsigned BC_W    = $clog2(NUM_BURSTS + 1);

    logic            busy_q;
    logic            wake_q;    // latched command kind
    logic            gap_q;     // 0 burst, 1 gap
    logic [PH_W-1:0] ph_cnt;
    logic [PH_W-1:0] gap_len;
    logic [BC_W-1:0] burst_cnt;
    logic            start;

    assign start   = (i_cmd.cominit | i_cmd.comwake) & ~busy_q;
    assign gap_len = wake_q ? PH_W'(COMWAKE_GAP) : PH_W'(COMINIT_GAP);

    //--------------------
    // burst and phase counters
    always_ff @(posedge i_tx_reset or posedge i_tx_clk) begin
        if (i_tx_clk) begin
            busy_q    <= 1'b0;
            wake_q    <= 1'b0;
            gap_q     <= 1'b0;
            ph_cnt    <= '0;
            burst_cnt <= '0;
        end else if (start) begin
            busy_q    <= 1'b1;
            wake_q    <= i_cmd.comwake;
            gap_q     <= 1'b0;            // train opens with a burst
            ph_cnt    <= '0;
            burst_cnt <= '0;
        end else if (busy_q) begin
            if (!gap_q && (ph_cnt == PH_W'(BURST_LEN - 1))) begin
                gap_q  <= 1'b1;
                ph_cnt <= '0;
            end else if (gap_q && (ph_cnt == gap_len - 1'b1)) begin
                gap_q  <= 1'b0;
                ph_cnt <= '0;
                if (burst_cnt == BC_W'(NUM_BURSTS - 1))
                    busy_q <= 1'b0;        // last gap done
                else
                    burst_cnt <= burst_cnt + 1'b1;
            end else begin
                ph_cnt <= ph_cnt + 1'b1;
            end
        end
    end

    assign o_ready    = ~busy_q;
    // active line while dialing or sending data
    assign o_elecidle = ~i_oob_done & ~(busy_q & ~gap_q);

endmodule

`default_nettype wire

// ==== source/sata_phy_pkg.sv ====
//--------------------
// link states, OOB command and event bundles
// timing defaults are in clock cycles and scaled down for simulation
//--------------------
`default_nettype none

package sata_phy_pkg;

    //--------------------
    // link-up FSM states
    typedef enum logic [3:0] {
        st_idle,
        st_send_comreset,
        st_suspend_comreset,
        st_wait_cominit,
        st_send_comwake,
        st_suspend_comwake,
        st_wait_comwake,
        st_wait_oobfinish,
        st_send_dial,
        st_step_gen,
        st_wait_settle,
        st_send_align,
        st_link_ready
    } link_state_e;

    // OOB requests, single-cycle pulses
    typedef struct packed {
        logic cominit;  // also used for COMRESET
        logic comwake;
    } oob_cmd_t;

    // OOB detections, single-cycle pulses
    typedef struct packed {
        logic cominit;
        logic comwake;
        logic oobfinish;
    } oob_event_t;

    //--------------------
    // timing defaults
    localparam int unsigned burst_len_c    = 4;    // idle-low cycles per burst
    localparam int unsigned cominit_gap_c  = 12;
    localparam int unsigned comwake_gap_c  = 4;
    localparam int unsigned num_bursts_c   = 6;    // bursts per sent train
    localparam int unsigned det_bursts_c   = 4;    // matching gaps to detect
    localparam int unsigned gap_tol_c      = 1;    // +/- cycles
    localparam int unsigned finish_len_c   = 16;   // sigdet high for end of OOB
    localparam int unsigned timeout_c      = 400;
    localparam int unsigned settle_c       = 20;   // wait after generation step
    localparam int unsigned align_period_c = 256;
    localparam int unsigned linkup_delay_c = 31;

endpackage

`default_nettype wire

// ==== source/sata_prims_pkg.sv ====
//--------------------
// SATA primitive dwords and dword containers
// byte 0 holds the K28.x character for primitives
// the received dword arrives already byte aligned
//--------------------
`default_nettype none

package sata_prims_pkg;

    //--------------------
    // primitive dwords
    localparam logic [31:0] prim_align_c = 32'h7B4A_4ABC;  // K28.5 D10.2 D10.2 D27.3
    localparam logic [31:0] prim_sync_c  = 32'hB5B5_957C;  // K28.3 D21.4 D21.5 D21.5
    localparam logic [31:0] dial_data_c  = 32'h4A4A_4A4A;  // D10.2 dial pattern

    // control flag of byte 0
    typedef enum logic {
        kind_data = 1'b0,
        kind_prim = 1'b1   // K28.x in byte 0
    } dword_kind_e;

    //--------------------
    // dword containers
    typedef struct packed {
        logic [31:0] data;
        dword_kind_e kind;
    } tx_dword_t;  // 33 bits

    typedef struct packed {
        logic [31:0] data;
        dword_kind_e kind;
        logic [3:0]  sync;  // per-byte sync status
    } rx_dword_t;  // 37 bits

    // link generation
    typedef enum logic [1:0] {
        gen_none = 2'd0,
        gen1     = 2'd1,
        gen2     = 2'd2,
        gen3     = 2'd3
    } sata_gen_e;

endpackage

`default_nettype wire
